// ==== design/bus_pkg.sv ====
package bus_pkg;

   // word-wide native bus, shared by front end and back end
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int NBYTES = DATA_W / 8;

   // byte address
   typedef logic [ADDR_W-1:0] addr_t;

   // one bus word
   typedef logic [DATA_W-1:0] data_t;

   // one strobe bit per byte lane
   typedef logic [NBYTES-1:0] strb_t;

   // data ram lane
   typedef logic [7:0] byte_t;

endpackage

// ==== design/cache_pkg.sv ====
package cache_pkg;

   // default geometry, all values are log2
   // two ways
   localparam int DEF_NWAYS_W  = 1;
   // eight sets
   localparam int DEF_NLINES_W = 3;
   // four words per line
   localparam int DEF_NWORDS_W = 2;

   // kind of front-end access
   typedef enum logic [1:0] {
      ACC_NONE,
      ACC_READ,
      ACC_WRITE
   } access_t;

endpackage

// ==== design/cache_mem_if.sv ====
interface cache_mem_if #(
   parameter int  LANES     = 2,
   parameter int  ADDR_BITS = 3,
   parameter type lane_t    = logic [7:0]
);

   logic                 en;
   // one write enable per lane
   logic [LANES-1:0]     we;
   logic [ADDR_BITS-1:0] addr;
   lane_t [LANES-1:0]    wdata;
   // valid the cycle after en
   lane_t [LANES-1:0]    rdata;

   modport ctrl (
      output en,
      output we,
      output addr,
      output wdata,
      input  rdata
   );

   modport ram (
      input  en,
      input  we,
      input  addr,
      input  wdata,
      output rdata
   );

endinterface

// ==== design/cache_ram.sv ====
module cache_ram #(
   parameter int  LANES     = 2,
   parameter int  ADDR_BITS = 3,
   parameter type lane_t    = logic [7:0]
) (
   input logic       clk_i,
   cache_mem_if.ram  port
);

   localparam int DEPTH = 2**ADDR_BITS;

   lane_t [LANES-1:0] mem [DEPTH];

   // write selected lanes, read old contents
   always_ff @(posedge clk_i) begin
      if (port.en) begin
         for (int l = 0; l < LANES; l++) begin
            if (port.we[l]) begin
               mem[port.addr][l] <= port.wdata[l];
            end
         end
         port.rdata <= mem[port.addr];
      end
   end

endmodule

// ==== design/cache_way_select.sv ====
module cache_way_select
   import bus_pkg::*;
#(
   parameter int   NWAYS_W  = 1,
   parameter int   NLINES_W = 3,
   parameter int   NWORDS_W = 2,
   localparam int  TAG_W    = ADDR_W - NLINES_W - NWORDS_W - $clog2(NBYTES)
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   cache_mem_if.ctrl           tag_port,
   input  logic [NLINES_W-1:0] index_i,
   input  logic [TAG_W-1:0]    tag_i,
   input  logic                fill_done_i,
   input  logic [NWAYS_W-1:0]  fill_way_i,
   input  logic                invalidate_i,
   output logic                hit_o,
   output logic [NWAYS_W-1:0]  hit_way_o,
   output logic [NWAYS_W-1:0]  victim_way_o
);

   localparam int NWAYS  = 2**NWAYS_W;
   localparam int NLINES = 2**NLINES_W;

   logic [NWAYS-1:0]   valid_q [NLINES];
   logic [NWAYS_W-1:0] rr_ptr_q [NLINES];
   logic [NWAYS-1:0]   set_valid;
   logic [NWAYS-1:0]   way_match;
   logic [NWAYS_W-1:0] first_free;
   logic               set_full;

   assign set_valid = valid_q[index_i];
   assign set_full  = &set_valid;

   // tag compare against the ways read last cycle
   always_comb begin
      for (int w = 0; w < NWAYS; w++) begin
         way_match[w] = set_valid[w] && (tag_port.rdata[w] == tag_i);
      end
   end

   assign hit_o = |way_match;

   // lowest matching way, only one should match
   always_comb begin
      hit_way_o = '0;
      for (int w = NWAYS-1; w >= 0; w--) begin
         if (way_match[w]) begin
            hit_way_o = NWAYS_W'(w);
         end
      end
   end

   // lowest invalid way
   always_comb begin
      first_free = '0;
      for (int w = NWAYS-1; w >= 0; w--) begin
         if (!set_valid[w]) begin
            first_free = NWAYS_W'(w);
         end
      end
   end

   assign victim_way_o = set_full ? rr_ptr_q[index_i] : first_free;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int s = 0; s < NLINES; s++) begin
            valid_q[s]  <= '0;
            rr_ptr_q[s] <= '0;
         end
      end else begin
         if (invalidate_i) begin
            for (int s = 0; s < NLINES; s++) begin
               valid_q[s] <= '0;
            end
         end
         // a line that just filled is valid even across an invalidate
         if (fill_done_i) begin
            valid_q[index_i][fill_way_i] <= 1'b1;
            if (set_full) begin
               rr_ptr_q[index_i] <= rr_ptr_q[index_i] + 1'b1;
            end
         end
      end
   end

endmodule

// ==== design/cache_control.sv ====
module cache_control
   import bus_pkg::*;
   import cache_pkg::*;
#(
   parameter int   NWAYS_W  = DEF_NWAYS_W,
   parameter int   NLINES_W = DEF_NLINES_W,
   parameter int   NWORDS_W = DEF_NWORDS_W,
   localparam int  NWAYS    = 2**NWAYS_W,
   localparam int  OFFS_W   = $clog2(NBYTES),
   localparam int  TAG_W    = ADDR_W - NLINES_W - NWORDS_W - OFFS_W
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                avalid_i,
   input  addr_t               addr_i,
   input  data_t               wdata_i,
   input  strb_t               wstrb_i,
   output logic                ready_o,
   output logic                rvalid_o,
   output data_t               rdata_o,
   output logic                be_avalid_o,
   output addr_t               be_addr_o,
   output data_t               be_wdata_o,
   output strb_t               be_wstrb_o,
   input  logic                be_ready_i,
   input  logic                be_rvalid_i,
   input  data_t               be_rdata_i,
   output logic                rd_hit_o,
   output logic                rd_miss_o,
   output logic                wr_hit_o,
   output logic                wr_miss_o,
   cache_mem_if.ctrl           tag_port,
   cache_mem_if.ctrl           data_port,
   input  logic                hit_i,
   input  logic [NWAYS_W-1:0]  hit_way_i,
   input  logic [NWAYS_W-1:0]  victim_way_i,
   output logic [NLINES_W-1:0] index_o,
   output logic [TAG_W-1:0]    tag_o,
   output logic                fill_done_o,
   output logic [NWAYS_W-1:0]  fill_way_o
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_LOOKUP,
      S_WRITE,
      S_FILL,
      S_RESP
   } state_t;

   state_t              state_q;
   state_t              state_d;
   access_t             acc_d;
   access_t             acc_q;
   addr_t               addr_q;
   data_t               wdata_q;
   strb_t               wstrb_q;
   data_t               rdata_q;
   logic [NWORDS_W-1:0] word_q;
   logic [NWORDS_W-1:0] cnt_q;
   logic                sent_q;
   logic [NWAYS_W-1:0]  fill_way_q;
   logic                lookup;
   logic                is_read;
   logic                is_write;
   logic                fill_beat;
   logic                last_word;

   // fields of the held request
   assign tag_o      = addr_q[ADDR_W-1 -: TAG_W];
   assign index_o    = addr_q[OFFS_W+NWORDS_W +: NLINES_W];
   assign word_q     = addr_q[OFFS_W +: NWORDS_W];
   assign fill_way_o = fill_way_q;

   always_comb begin
      if (!avalid_i) begin
         acc_d = ACC_NONE;
      end else if (|wstrb_i) begin
         acc_d = ACC_WRITE;
      end else begin
         acc_d = ACC_READ;
      end
   end

   assign lookup    = (state_q == S_LOOKUP);
   assign is_read   = (acc_q == ACC_READ);
   assign is_write  = (acc_q == ACC_WRITE);
   // a fill word arrives only after its request was taken
   assign fill_beat = (state_q == S_FILL) && sent_q && be_rvalid_i;
   assign last_word = &cnt_q;

   assign ready_o   = (state_q == S_IDLE);
   assign rd_hit_o  = lookup && is_read && hit_i;
   assign rd_miss_o = lookup && is_read && !hit_i;
   assign wr_hit_o  = lookup && is_write && hit_i;
   assign wr_miss_o = lookup && is_write && !hit_i;

   // hit word straight from the data ram, fill word from the register
   assign rvalid_o = rd_hit_o || (state_q == S_RESP);
   assign rdata_o  = (state_q == S_RESP) ? rdata_q
                                         : data_port.rdata[hit_way_i*NBYTES +: NBYTES];

   // back end: write-through or one line word per transaction
   assign be_avalid_o = (lookup && is_write) || (state_q == S_WRITE) ||
                        ((state_q == S_FILL) && !sent_q);
   assign be_addr_o   = (state_q == S_FILL) ?
                        {addr_q[ADDR_W-1:OFFS_W+NWORDS_W], cnt_q, OFFS_W'(0)} :
                        {addr_q[ADDR_W-1:OFFS_W], OFFS_W'(0)};
   assign be_wdata_o  = wdata_q;
   assign be_wstrb_o  = (state_q == S_FILL) ? '0 : wstrb_q;

   // ram ports
   always_comb begin
      tag_port.en     = 1'b0;
      tag_port.we     = '0;
      tag_port.addr   = index_o;
      tag_port.wdata  = {NWAYS{tag_o}};
      data_port.en    = 1'b0;
      data_port.we    = '0;
      data_port.addr  = {index_o, word_q};
      data_port.wdata = {NWAYS{wdata_q}};
      fill_done_o     = 1'b0;
      case (state_q)
         S_IDLE: begin
            // read both arrays for the incoming request
            tag_port.en    = avalid_i;
            tag_port.addr  = addr_i[OFFS_W+NWORDS_W +: NLINES_W];
            data_port.en   = avalid_i;
            data_port.addr = addr_i[OFFS_W +: NLINES_W+NWORDS_W];
         end
         S_LOOKUP: begin
            if (is_write && hit_i) begin
               data_port.en = 1'b1;
               data_port.we = (NWAYS*NBYTES)'(wstrb_q) << (hit_way_i * NBYTES);
            end
         end
         S_FILL: begin
            data_port.addr  = {index_o, cnt_q};
            data_port.wdata = {NWAYS{be_rdata_i}};
            if (fill_beat) begin
               data_port.en = 1'b1;
               data_port.we = (NWAYS*NBYTES)'({NBYTES{1'b1}}) << (fill_way_q * NBYTES);
               // new tag goes in with the last word
               if (last_word) begin
                  tag_port.en = 1'b1;
                  tag_port.we = NWAYS'(1) << fill_way_q;
                  fill_done_o = 1'b1;
               end
            end
         end
         default: begin
         end
      endcase
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         S_IDLE: begin
            if (avalid_i) state_d = S_LOOKUP;
         end
         S_LOOKUP: begin
            if (is_write) begin
               state_d = be_ready_i ? S_IDLE : S_WRITE;
            end else if (hit_i) begin
               state_d = S_IDLE;
            end else begin
               state_d = S_FILL;
            end
         end
         S_WRITE: begin
            if (be_ready_i) state_d = S_IDLE;
         end
         S_FILL: begin
            if (fill_beat && last_word) state_d = S_RESP;
         end
         default: state_d = S_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= S_IDLE;
         acc_q   <= ACC_NONE;
         cnt_q   <= '0;
         sent_q  <= 1'b0;
      end else begin
         state_q <= state_d;
         if (ready_o) acc_q <= acc_d;
         if (lookup) begin
            cnt_q  <= '0;
            sent_q <= 1'b0;
         end else if (state_q == S_FILL) begin
            if (!sent_q && be_ready_i) sent_q <= 1'b1;
            if (fill_beat) begin
               sent_q <= 1'b0;
               cnt_q  <= cnt_q + 1'b1;
            end
         end
      end
   end

   // request payload and fill bookkeeping
   always_ff @(posedge clk_i) begin
      if (ready_o && avalid_i) begin
         addr_q  <= addr_i;
         wdata_q <= wdata_i;
         wstrb_q <= wstrb_i;
      end
      if (lookup) fill_way_q <= victim_way_i;
      // keep the requested word as it goes by
      if (fill_beat && (cnt_q == word_q)) rdata_q <= be_rdata_i;
   end

endmodule

// ==== design/cache_top.sv ====
module cache_top
   import bus_pkg::*;
   import cache_pkg::*;
#(
   parameter int NWAYS_W  = DEF_NWAYS_W,
   parameter int NLINES_W = DEF_NLINES_W,
   parameter int NWORDS_W = DEF_NWORDS_W
) (
   input  logic  clk_i,
   input  logic  rst_n_i,
   // front end
   input  logic  avalid_i,
   input  addr_t addr_i,
   input  data_t wdata_i,
   input  strb_t wstrb_i,
   output logic  ready_o,
   output logic  rvalid_o,
   output data_t rdata_o,
   // back end toward memory
   output logic  be_avalid_o,
   output addr_t be_addr_o,
   output data_t be_wdata_o,
   output strb_t be_wstrb_o,
   input  logic  be_ready_i,
   input  logic  be_rvalid_i,
   input  data_t be_rdata_i,
   // monitor
   input  logic  invalidate_i,
   output logic  rd_hit_o,
   output logic  rd_miss_o,
   output logic  wr_hit_o,
   output logic  wr_miss_o
);

   localparam int NWAYS = 2**NWAYS_W;
   localparam int TAG_W = ADDR_W - NLINES_W - NWORDS_W - $clog2(NBYTES);

   typedef logic [TAG_W-1:0] tag_t;

   logic                hit;
   logic [NWAYS_W-1:0]  hit_way;
   logic [NWAYS_W-1:0]  victim_way;
   logic [NWAYS_W-1:0]  fill_way;
   logic [NLINES_W-1:0] index;
   logic [TAG_W-1:0]    tag;
   logic                fill_done;

   // tag per way, data bytes of all ways side by side
   cache_mem_if #(.LANES(NWAYS), .ADDR_BITS(NLINES_W), .lane_t(tag_t)) tag_port ();
   cache_mem_if #(
      .LANES(NWAYS*NBYTES), .ADDR_BITS(NLINES_W+NWORDS_W), .lane_t(byte_t)
   ) data_port ();

   cache_control #(
      .NWAYS_W(NWAYS_W), .NLINES_W(NLINES_W), .NWORDS_W(NWORDS_W)
   ) u_control (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .avalid_i(avalid_i), .addr_i(addr_i), .wdata_i(wdata_i), .wstrb_i(wstrb_i),
      .ready_o(ready_o), .rvalid_o(rvalid_o), .rdata_o(rdata_o),
      .be_avalid_o(be_avalid_o), .be_addr_o(be_addr_o),
      .be_wdata_o(be_wdata_o), .be_wstrb_o(be_wstrb_o),
      .be_ready_i(be_ready_i), .be_rvalid_i(be_rvalid_i), .be_rdata_i(be_rdata_i),
      .rd_hit_o(rd_hit_o), .rd_miss_o(rd_miss_o),
      .wr_hit_o(wr_hit_o), .wr_miss_o(wr_miss_o),
      .tag_port(tag_port.ctrl), .data_port(data_port.ctrl),
      .hit_i(hit), .hit_way_i(hit_way), .victim_way_i(victim_way),
      .index_o(index), .tag_o(tag), .fill_done_o(fill_done), .fill_way_o(fill_way)
   );

   cache_way_select #(
      .NWAYS_W(NWAYS_W), .NLINES_W(NLINES_W), .NWORDS_W(NWORDS_W)
   ) u_way_select (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .tag_port(tag_port.ctrl),
      .index_i(index), .tag_i(tag),
      .fill_done_i(fill_done), .fill_way_i(fill_way), .invalidate_i(invalidate_i),
      .hit_o(hit), .hit_way_o(hit_way), .victim_way_o(victim_way)
   );

   cache_ram #(.LANES(NWAYS), .ADDR_BITS(NLINES_W), .lane_t(tag_t)) tag_ram (
      .clk_i(clk_i),
      .port(tag_port.ram)
   );

   cache_ram #(
      .LANES(NWAYS*NBYTES), .ADDR_BITS(NLINES_W+NWORDS_W), .lane_t(byte_t)
   ) data_ram (
      .clk_i(clk_i),
      .port(data_port.ram)
   );

endmodule

// ==== test/cache_tb_model.svh ====
`ifndef CACHE_TB_MODEL_SVH
`define CACHE_TB_MODEL_SVH

// expected main memory, one word per entry
data_t model_mem [MEM_WORDS];
// expected cache state per set and way
logic  model_valid [NSETS][NWAYS];
int    model_tag [NSETS][NWAYS];
// round-robin pointer per set
int    model_rr [NSETS];

// start value of a memory word, from its word address
function automatic data_t fill_word(input int idx);
   return (data_t'(idx) * 32'h0101_0103) ^ 32'h5a3c_0000;
endfunction

function automatic data_t merge_bytes(input data_t old, input data_t wdata, input strb_t wstrb);
   data_t res;
   res = old;
   for (int b = 0; b < NBYTES; b++) begin
      if (wstrb[b]) begin
         res[8*b +: 8] = wdata[8*b +: 8];
      end
   end
   return res;
endfunction

task automatic clear_model_valid();
   for (int s = 0; s < NSETS; s++) begin
      for (int w = 0; w < NWAYS; w++) begin
         model_valid[s][w] = 1'b0;
      end
   end
endtask

task automatic init_model();
   for (int i = 0; i < MEM_WORDS; i++) begin
      model_mem[i] = fill_word(i);
   end
   for (int s = 0; s < NSETS; s++) begin
      model_rr[s] = 0;
   end
   clear_model_valid();
endtask

// hit or miss, then write-through or line fill
task automatic predict_access(input access_t kind, input addr_t addr, input data_t wdata,
                              input strb_t wstrb, output logic hit, output data_t rdata);
   int set;
   int tag;
   int idx;
   int victim;
   set    = int'(addr >> SET_LSB) % NSETS;
   tag    = int'(addr >> TAG_LSB);
   idx    = int'(addr >> OFFS_W) % MEM_WORDS;
   hit    = 1'b0;
   victim = -1;
   for (int w = 0; w < NWAYS; w++) begin
      if (model_valid[set][w] && model_tag[set][w] == tag) begin
         hit = 1'b1;
      end
      // lowest invalid way first
      if (!model_valid[set][w] && victim < 0) begin
         victim = w;
      end
   end
   if (kind == ACC_WRITE) begin
      model_mem[idx] = merge_bytes(model_mem[idx], wdata, wstrb);
   end else if (!hit) begin
      // full set, take the pointer and move it on
      if (victim < 0) begin
         victim        = model_rr[set];
         model_rr[set] = (model_rr[set] + 1) % NWAYS;
      end
      model_valid[set][victim] = 1'b1;
      model_tag[set][victim]   = tag;
   end
   rdata = model_mem[idx];
endtask

`endif

// ==== test/cache_tb.sv ====
module cache_tb
   import bus_pkg::*;
   import cache_pkg::*;
();

   localparam int NWAYS     = 2**DEF_NWAYS_W;
   localparam int NSETS     = 2**DEF_NLINES_W;
   localparam int OFFS_W    = $clog2(NBYTES);
   localparam int SET_LSB   = OFFS_W + DEF_NWORDS_W;
   localparam int TAG_LSB   = SET_LSB + DEF_NLINES_W;
   // backing memory spans eight tags
   localparam int MEM_WORDS = 256;
   localparam int TIMEOUT   = 500;

   logic  clk_i = 1'b0;
   logic  rst_n_i;
   logic  avalid_i;
   addr_t addr_i;
   data_t wdata_i;
   strb_t wstrb_i;
   logic  ready_o;
   logic  rvalid_o;
   data_t rdata_o;
   logic  be_avalid_o;
   addr_t be_addr_o;
   data_t be_wdata_o;
   strb_t be_wstrb_o;
   logic  be_ready_i;
   logic  be_rvalid_i;
   data_t be_rdata_i;
   logic  invalidate_i;
   logic  rd_hit_o;
   logic  rd_miss_o;
   logic  wr_hit_o;
   logic  wr_miss_o;

   integer stim_seed     = 32'h83b5_32d9;
   integer stall_seed    = 32'h83b5_32d9;
   int     errors        = 0;
   int     checks        = 0;
   int     test_num      = 0;
   int     test_err_base = 0;
   // back-end memory and its single outstanding read
   data_t  be_mem [MEM_WORDS];
   logic   rd_pending    = 1'b0;
   int     rd_delay      = 0;
   addr_t  rd_addr;
   // what the DUT reported for the current request
   int     pulse_q [$];
   data_t  rdata_q [$];

   `include "cache_tb_model.svh"

   cache_top uut (.*);

   initial begin
      forever #10 clk_i = ~clk_i;
   end

   // back-end handshakes taken at the rising edge
   always @(posedge clk_i) begin
      if (rst_n_i && be_avalid_o && be_ready_i) begin
         if (|be_wstrb_o) begin
            be_mem[(be_addr_o >> OFFS_W) % MEM_WORDS] =
               merge_bytes(be_mem[(be_addr_o >> OFFS_W) % MEM_WORDS], be_wdata_o, be_wstrb_o);
         end else begin
            if (rd_pending) begin
               $display("%0t: second back-end read taken while one is outstanding", $time);
               errors++;
            end
            rd_pending = 1'b1;
            rd_addr    = be_addr_o;
            rd_delay   = {$random(stall_seed)} % 3;
         end
      end
   end

   // random stalls and read data driven on the falling edge
   always @(negedge clk_i) begin
      be_ready_i  = ({$random(stall_seed)} % 4) != 0;
      be_rvalid_i = 1'b0;
      if (rd_pending) begin
         if (rd_delay == 0) begin
            be_rvalid_i = 1'b1;
            be_rdata_i  = be_mem[(rd_addr >> OFFS_W) % MEM_WORDS];
            rd_pending  = 1'b0;
         end else begin
            rd_delay--;
         end
      end
   end

   // monitor pulses and read responses
   always @(posedge clk_i) begin
      if (rst_n_i) begin
         if (rd_hit_o) pulse_q.push_back(0);
         if (rd_miss_o) pulse_q.push_back(1);
         if (wr_hit_o) pulse_q.push_back(2);
         if (wr_miss_o) pulse_q.push_back(3);
         if (rvalid_o) rdata_q.push_back(rdata_o);
      end
   end

   function automatic addr_t line_addr(input int tag, input int set, input int word);
      return addr_t'((tag << TAG_LSB) | (set << SET_LSB) | (word << OFFS_W));
   endfunction

   function automatic string pulse_name(input int code);
      case (code)
         0: return "rd_hit_o";
         1: return "rd_miss_o";
         2: return "wr_hit_o";
         default: return "wr_miss_o";
      endcase
   endfunction

   task automatic abort_run(input string why);
      $display("%0t: %s", $time, why);
      $display("ERRORS FOUND");
      $finish;
   endtask

   task automatic wait_for_ready();
      int waited;
      waited = 0;
      while (!ready_o) begin
         if (waited >= TIMEOUT) abort_run("timeout waiting for ready_o");
         @(negedge clk_i);
         waited++;
      end
   endtask

   // one front-end request checked once the DUT is idle again
   task automatic run_access(input access_t kind, input addr_t addr, input data_t wdata,
                             input strb_t wstrb);
      logic  exp_hit;
      data_t exp_rdata;
      int    exp_pulse;
      wait_for_ready();
      pulse_q.delete();
      rdata_q.delete();
      avalid_i = 1'b1;
      addr_i   = addr;
      wdata_i  = wdata;
      wstrb_i  = (kind == ACC_WRITE) ? wstrb : '0;
      @(negedge clk_i);
      avalid_i = 1'b0;
      wstrb_i  = '0;
      wait_for_ready();
      predict_access(kind, addr, wdata, wstrb, exp_hit, exp_rdata);
      exp_pulse = (kind == ACC_READ) ? (exp_hit ? 0 : 1) : (exp_hit ? 2 : 3);
      checks++;
      if (pulse_q.size() != 1) begin
         $display("%0t: %0d monitor pulses for the request to %h", $time, pulse_q.size(), addr);
         errors++;
      end else if (pulse_q[0] != exp_pulse) begin
         $display("MISMATCH at %0t: monitor pulse got %s expected %s", $time,
                  pulse_name(pulse_q[0]), pulse_name(exp_pulse));
         errors++;
      end
      checks++;
      if (kind == ACC_READ && rdata_q.size() != 1) begin
         $display("%0t: %0d rvalid_o pulses for the read of %h", $time, rdata_q.size(), addr);
         errors++;
      end else if (kind == ACC_WRITE && rdata_q.size() != 0) begin
         $display("%0t: rvalid_o pulsed for the write to %h", $time, addr);
         errors++;
      end else if (kind == ACC_READ && rdata_q[0] !== exp_rdata) begin
         $display("MISMATCH at %0t: rdata_o got %h expected %h", $time, rdata_q[0], exp_rdata);
         errors++;
      end
   endtask

   task automatic pulse_invalidate();
      invalidate_i = 1'b1;
      @(negedge clk_i);
      invalidate_i = 1'b0;
      clear_model_valid();
   endtask

   task automatic compare_memory();
      for (int i = 0; i < MEM_WORDS; i++) begin
         checks++;
         if (be_mem[i] !== model_mem[i]) begin
            $display("MISMATCH at %0t: be_mem[%0d] got %h expected %h", $time, i,
                     be_mem[i], model_mem[i]);
            errors++;
         end
      end
   endtask

   task automatic end_test(input string name);
      test_num++;
      $display("test %0d %s: %0d errors", test_num, name, errors - test_err_base);
      test_err_base = errors;
   endtask

   initial begin
      logic [31:0] r;
      strb_t       strb;
      rst_n_i      = 1'b0;
      avalid_i     = 1'b0;
      addr_i       = '0;
      wdata_i      = '0;
      wstrb_i      = '0;
      be_ready_i   = 1'b0;
      be_rvalid_i  = 1'b0;
      be_rdata_i   = '0;
      invalidate_i = 1'b0;
      init_model();
      for (int i = 0; i < MEM_WORDS; i++) begin
         be_mem[i] = fill_word(i);
      end
      repeat (16) @(negedge clk_i);
      rst_n_i = 1'b1;
      @(negedge clk_i);
      checks++;
      if (ready_o !== 1'b1 || rvalid_o !== 1'b0 || be_avalid_o !== 1'b0 ||
          rd_hit_o !== 1'b0 || rd_miss_o !== 1'b0 || wr_hit_o !== 1'b0 ||
          wr_miss_o !== 1'b0) begin
         $display("%0t: outputs are not idle after reset", $time);
         errors++;
      end

      run_access(ACC_READ, line_addr(0, 1, 2), '0, '0);
      run_access(ACC_READ, line_addr(0, 1, 0), '0, '0);
      end_test("read miss then hit");

      run_access(ACC_WRITE, line_addr(0, 1, 2), 32'hdead_beef, 4'b0101);
      run_access(ACC_WRITE, line_addr(1, 2, 3), 32'h1234_5678, 4'b1010);
      run_access(ACC_READ, line_addr(0, 1, 2), '0, '0);
      run_access(ACC_READ, line_addr(1, 2, 3), '0, '0);
      compare_memory();
      end_test("strobed write hit and miss");

      // three tags into two ways of set 5
      run_access(ACC_READ, line_addr(1, 5, 0), '0, '0);
      run_access(ACC_READ, line_addr(2, 5, 1), '0, '0);
      run_access(ACC_READ, line_addr(3, 5, 2), '0, '0);
      run_access(ACC_READ, line_addr(1, 5, 3), '0, '0);
      run_access(ACC_READ, line_addr(3, 5, 0), '0, '0);
      run_access(ACC_READ, line_addr(2, 5, 1), '0, '0);
      run_access(ACC_READ, line_addr(1, 5, 2), '0, '0);
      end_test("replacement order");

      run_access(ACC_READ, line_addr(0, 1, 0), '0, '0);
      pulse_invalidate();
      run_access(ACC_READ, line_addr(0, 1, 0), '0, '0);
      run_access(ACC_READ, line_addr(1, 2, 3), '0, '0);
      run_access(ACC_READ, line_addr(0, 1, 1), '0, '0);
      end_test("invalidate");

      for (int n = 0; n < 400; n++) begin
         r    = $random(stim_seed);
         strb = r[4:1];
         if (strb == '0) strb = '1;
         run_access(r[0] ? ACC_WRITE : ACC_READ, line_addr(r[6:5], r[9:7], r[11:10]),
                    data_t'($random(stim_seed)), strb);
      end
      compare_memory();
      end_test("random mix");

      $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
design/bus_pkg.sv
design/cache_pkg.sv
design/cache_mem_if.sv
design/cache_ram.sv
design/cache_way_select.sv
design/cache_control.sv
design/cache_top.sv
+incdir+test
test/cache_tb.sv
